// ==== test/vlsu_testdata.txt ====
# M|R word_addr value count : preload count words with value+k, all hex
# Q op vd rs1 vl vsew backpressure name ; E M|R word_addr value count : expect value+k
M 040 10000000 8
Q 0 2 00000100 8 2 0 load32_vl8
E R 010 10000000 8
R 020 aaaaaaaa 2
M 050 21212121 2
Q 0 4 00000140 5 0 0 load8_vl5
E R 020 21212121 1
E R 021 aaaaaa22 1
R 030 31323334 2
M 060 cccccccc 3
Q 1 6 00000180 3 1 0 store16_vl3
E M 060 31323334 1
E M 061 cccc3335 1
E M 062 ccccccce 1
M 100 40000000 18
Q 0 8 00000400 18 2 0 load32_vl24
E R 040 40000000 18
R 050 5a5a5a5a 1
Q 0 a 00000000 0 2 0 zero_vl
E R 050 5a5a5a5a 1
R 0a0 60000000 8
Q 1 14 00000800 8 2 1 store32_bp
E M 200 60000000 8
Q 0 18 00000800 8 2 1 load32_bp
E R 0c0 60000000 8

// ==== build.f ====
+incdir+design
design/vlsu_op_pkg.sv
design/vlsu_bus_pkg.sv
design/vlsu_req_ctrl.sv
design/vlsu_reorder_buffer.sv
design/vlsu_mem_seq.sv
design/vlsu_vrf_seq.sv
design/vlsu_top.sv
test/vlsu_assertions.sv
test/vlsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vlsu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard design/*) $(wildcard test/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/vlsu_tb.sv ====
// Testbench for the vector load/store unit
// Memory and register file models, stimulus and expected words from a data file
`timescale 1ns/1ps

module vlsu_tb;

  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned VRF_WORDS = 256;
  localparam string       DATA_FILE = "test/vlsu_testdata.txt";

  logic                      clk_i;
  logic                      rst_i;
  vlsu_op_pkg::vlsu_req_t    req_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  vlsu_bus_pkg::mem_req_t    mem_req_o;
  logic                      mem_valid_o;
  logic                      mem_ready_i;
  vlsu_bus_pkg::mem_result_t mem_result_i;
  logic                      mem_result_valid_i;
  vlsu_bus_pkg::vrf_wr_t     vrf_wr_o;
  logic                      vrf_we_o;
  logic                      vrf_wvalid_i;
  vlsu_bus_pkg::vrf_addr_t   vrf_raddr_o;
  logic                      vrf_re_o;
  vlsu_bus_pkg::word_t       vrf_rdata_i;
  logic                      vrf_rvalid_i;

  vlsu_bus_pkg::word_t mem [MEM_WORDS];
  vlsu_bus_pkg::word_t vrf [VRF_WORDS];
  // Load results waiting in the memory model
  vlsu_bus_pkg::tag_t  pend_tag [$];
  vlsu_bus_pkg::word_t pend_data [$];
  int                  pend_delay [$];
  // Port values for the next rising edge
  vlsu_bus_pkg::mem_result_t result_next;
  logic                      result_next_valid;
  logic                      mem_ready_next;
  logic                      vrf_wvalid_next;
  logic [31:0]         rng;
  logic                bp;
  int unsigned         cycles;
  int unsigned         cycle_limit;
  int unsigned         value_errors;
  int unsigned         other_errors;
  int unsigned         mem_beats;
  int unsigned         vrf_beats;
  int unsigned         exp_beats;
  string               cur_name;

  vlsu_top dut0 (.*);

  // Register file answers reads in the same cycle
  assign vrf_rdata_i  = vrf[vrf_raddr_o];
  assign vrf_rvalid_i = vrf_re_o;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Port models
  ////////////////////////////////////////

  // Transfers are taken at the falling edge where all handshake inputs are stable
  always @(negedge clk_i) begin : sample_ports
    int unsigned idx;
    int          sel;
    sel = -1;
    if (!rst_i) begin
      if (mem_valid_o && mem_ready_i) begin
        mem_beats++;
        idx = int'(mem_req_o.addr[11:2]);
        assert (mem_req_o.last === (mem_beats == exp_beats)) else begin
          value_errors++;
          $display("ERR %s last of beat %0d expected %b actual %b", cur_name, mem_beats,
                   mem_beats == exp_beats, mem_req_o.last);
        end
        if (mem_req_o.we) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_req_o.strb[k]) mem[idx][8*k +: 8] = mem_req_o.wdata[8*k +: 8];
          end
        end else begin
          rng = xorshift(rng);
          pend_tag.push_back(mem_req_o.tag);
          pend_data.push_back(mem[idx]);
          pend_delay.push_back(1 + int'(rng[3:0]));
        end
      end
      if (vrf_we_o && vrf_wvalid_i) begin
        vrf_beats++;
        for (int k = 0; k < 4; k++) begin
          if (vrf_wr_o.be[k]) vrf[vrf_wr_o.addr][8*k +: 8] = vrf_wr_o.data[8*k +: 8];
        end
      end
      if (vrf_re_o) vrf_beats++;
    end
    // Oldest result whose delay has run out goes out next
    for (int i = 0; i < pend_delay.size(); i++) begin
      if (pend_delay[i] == 0 && sel < 0) sel = i;
      else if (pend_delay[i] > 0) pend_delay[i]--;
    end
    if (sel >= 0) begin
      result_next       = '{tag: pend_tag[sel], rdata: pend_data[sel]};
      result_next_valid = 1'b1;
      pend_tag.delete(sel);
      pend_data.delete(sel);
      pend_delay.delete(sel);
    end else begin
      result_next_valid = 1'b0;
    end
    rng = xorshift(rng);
    mem_ready_next  = !bp || rng[0] || rng[1];
    vrf_wvalid_next = !bp || rng[2] || rng[3];
  end

  always @(posedge clk_i) begin : drive_ports
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the unit never finished", cycles);
      $display("=== FAIL ===");
      $finish;
    end else begin
      mem_ready_i        <= mem_ready_next;
      vrf_wvalid_i       <= vrf_wvalid_next;
      mem_result_i       <= result_next;
      mem_result_valid_i <= result_next_valid;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic run_request(input logic [31:0] op, vd, rs1, vl, ew, bpf, input string name);
    @(posedge clk_i);
    bp          <= bpf[0];
    req_i       <= '{op: vlsu_op_pkg::vlsu_op_e'(op[0]), vd: vd[4:0], rs1: rs1,
                     vl: vl[8:0], vsew: vlsu_op_pkg::vsew_e'(ew[1:0])};
    req_valid_i <= 1'b1;
    mem_beats = 0;
    vrf_beats = 0;
    // One memory beat and one register file beat per word
    exp_beats = ((vl << ew) + 3) >> 2;
    cur_name  = name;
    @(negedge clk_i);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    if (vl == 0) begin
      repeat (4) begin
        @(negedge clk_i);
        assert (req_ready_o === 1'b1) else begin
          value_errors++;
          $display("ERR %s ready expected 1 actual %b", name, req_ready_o);
        end
      end
      assert (mem_beats + vrf_beats == 0) else begin
        value_errors++;
        $display("ERR %s beats expected 0 actual %0d", name, mem_beats + vrf_beats);
      end
    end else begin
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      assert (mem_beats == exp_beats && vrf_beats == exp_beats) else begin
        value_errors++;
        $display("ERR %s beats expected %0d actual %0d memory %0d register file", name,
                 exp_beats, mem_beats, vrf_beats);
      end
    end
  endtask

  task automatic check_words(input bit is_mem, input logic [31:0] addr, val, cnt,
                             input string name);
    vlsu_bus_pkg::word_t got;
    vlsu_bus_pkg::word_t exp;
    for (int unsigned k = 0; k < cnt; k++) begin
      got = is_mem ? mem[(addr + k) % MEM_WORDS] : vrf[(addr + k) % VRF_WORDS];
      exp = val + k;
      assert (got === exp) else begin
        value_errors++;
        $display("ERR %s %s[%0h] expected %h actual %h", name, is_mem ? "mem" : "vrf",
                 addr + k, exp, got);
      end
    end
  endtask

  task automatic run_file(input bit count_only);
    int          fd;
    int          n;
    string       line;
    string       kind;
    string       space;
    string       name;
    logic [31:0] a, b, c, d, e, f;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the stimulus file %s", DATA_FILE);
      return;
    end
    while ($fgets(line, fd)) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s", kind);
      if (n != 1) continue;
      if (kind == "Q") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %s", kind, a, b, c, d, e, f, name);
        if (count_only) begin
          cycle_limit += 64 * (((d << e) + 3) >> 2);
        end else if (n != 8) begin
          other_errors++;
          $display("Incomplete request record in the stimulus file: %s", line);
        end else begin
          run_request(a, b, c, d, e, f, name);
        end
      end else if (count_only) begin
        continue;
      end else if (kind == "M" || kind == "R") begin
        n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
        if (n != 4) begin
          other_errors++;
          $display("Incomplete preload record in the stimulus file: %s", line);
        end else begin
          for (int unsigned k = 0; k < c; k++) begin
            if (kind == "M") mem[(a + k) % MEM_WORDS] = b + k;
            else vrf[(a + k) % VRF_WORDS] = b + k;
          end
        end
      end else if (kind == "E") begin
        n = $sscanf(line, "%s %s %h %h %h", kind, space, a, b, c);
        if (n != 5) begin
          other_errors++;
          $display("Incomplete expect record in the stimulus file: %s", line);
        end else begin
          check_words(space == "M", a, b, c, name);
        end
      end else begin
        other_errors++;
        $display("Unknown record in the stimulus file: %s", line);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    rst_i              = 1'b1;
    req_i              = '0;
    req_valid_i        = 1'b0;
    mem_ready_i        = 1'b1;
    mem_result_i       = '0;
    mem_result_valid_i = 1'b0;
    vrf_wvalid_i       = 1'b1;
    result_next        = '0;
    result_next_valid  = 1'b0;
    mem_ready_next     = 1'b1;
    vrf_wvalid_next    = 1'b1;
    rng                = 32'hbc8938a4;
    bp                 = 1'b0;
    cycles             = 0;
    cycle_limit        = 0;
    value_errors       = 0;
    other_errors       = 0;
    mem_beats          = 0;
    vrf_beats          = 0;
    exp_beats          = 0;
    cur_name           = "";
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = {16'(i) ^ 16'h5a00, ~16'(i)};
    for (int i = 0; i < VRF_WORDS; i++) vrf[i] = {16'hd00d ^ 16'(i), 16'(i * 3)};
    run_file(1'b1);
    cycle_limit += 200;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    run_file(1'b0);
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== test/vlsu_assertions.sv ====
// Protocol checks for the vector load/store unit
// Bound to the top level to watch the memory port, register file enables and ready
`timescale 1ns/1ps

module vlsu_assertions (
  input logic                   clk_i,
  input logic                   rst_i,
  input vlsu_op_pkg::vlsu_req_t req_i,
  input logic                   req_valid_i,
  input logic                   req_ready_o,
  input vlsu_bus_pkg::mem_req_t mem_req_o,
  input logic                   mem_valid_o,
  input logic                   mem_ready_i,
  input logic                   vrf_we_o,
  input logic                   vrf_re_o
);

  // Memory request holds while the port stalls
  mem_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o))
    else $error("memory request changed while mem_ready_i was low");

  // Register file is either written or read
  vrf_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(vrf_we_o && vrf_re_o))
    else $error("register file write and read enabled together");

  reset_quiet_a: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !mem_valid_o && !vrf_we_o && !vrf_re_o)
    else $error("control outputs high during reset");

  // Ready only falls when a request with elements is taken
  ready_idle_a: assert property (@(posedge clk_i) disable iff (rst_i)
    req_ready_o && !(req_valid_i && req_i.vl != '0) |=> req_ready_o)
    else $error("req_ready_o fell although no job was accepted");

endmodule

bind vlsu_top vlsu_assertions u_assertions (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_i      (req_i),
  .req_valid_i(req_valid_i),
  .req_ready_o(req_ready_o),
  .mem_req_o  (mem_req_o),
  .mem_valid_o(mem_valid_o),
  .mem_ready_i(mem_ready_i),
  .vrf_we_o   (vrf_we_o),
  .vrf_re_o   (vrf_re_o)
);

// ==== design/vlsu_top.sv ====
// Vector load/store unit top level
// Request control, reorder buffer and the memory and register file sequencers
`timescale 1ns/1ps

module vlsu_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  vlsu_op_pkg::vlsu_req_t    req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output vlsu_bus_pkg::mem_req_t    mem_req_o,
  output logic                      mem_valid_o,
  input  logic                      mem_ready_i,
  input  vlsu_bus_pkg::mem_result_t mem_result_i,
  input  logic                      mem_result_valid_i,
  output vlsu_bus_pkg::vrf_wr_t     vrf_wr_o,
  output logic                      vrf_we_o,
  input  logic                      vrf_wvalid_i,
  output vlsu_bus_pkg::vrf_addr_t   vrf_raddr_o,
  output logic                      vrf_re_o,
  input  vlsu_bus_pkg::word_t       vrf_rdata_i,
  input  logic                      vrf_rvalid_i
);

  vlsu_op_pkg::vlsu_job_t job;
  vlsu_bus_pkg::tag_t     alloc_tag;
  vlsu_bus_pkg::word_t    head_data;
  vlsu_bus_pkg::word_t    append_data;
  logic                   start;
  logic                   active;
  logic                   mem_busy;
  logic                   vrf_busy;
  logic                   rob_full;
  logic                   alloc;
  logic                   append;
  logic                   head_valid;
  logic                   mem_pop;
  logic                   vrf_pop;

  vlsu_req_ctrl u_req_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .mem_busy_i (mem_busy),
    .vrf_busy_i (vrf_busy),
    .job_o      (job),
    .start_o    (start),
    .active_o   (active)
  );

  // Loads pop from the register file side, stores from the memory side
  vlsu_reorder_buffer u_rob (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (start),
    .alloc_i      (alloc),
    .alloc_tag_o  (alloc_tag),
    .fill_i       (mem_result_valid_i),
    .fill_tag_i   (mem_result_i.tag),
    .fill_data_i  (mem_result_i.rdata),
    .append_i     (append),
    .append_data_i(append_data),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .pop_i        (mem_pop | vrf_pop),
    .full_o       (rob_full)
  );

  vlsu_mem_seq u_mem_seq (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .job_i       (job),
    .start_i     (start),
    .active_i    (active),
    .full_i      (rob_full),
    .alloc_o     (alloc),
    .alloc_tag_i (alloc_tag),
    .head_valid_i(head_valid),
    .head_data_i (head_data),
    .pop_o       (mem_pop),
    .mem_req_o   (mem_req_o),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .busy_o      (mem_busy)
  );

  vlsu_vrf_seq u_vrf_seq (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .job_i        (job),
    .start_i      (start),
    .active_i     (active),
    .full_i       (rob_full),
    .head_valid_i (head_valid),
    .head_data_i  (head_data),
    .pop_o        (vrf_pop),
    .append_o     (append),
    .append_data_o(append_data),
    .vrf_wr_o     (vrf_wr_o),
    .vrf_we_o     (vrf_we_o),
    .vrf_wvalid_i (vrf_wvalid_i),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_re_o     (vrf_re_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .busy_o       (vrf_busy)
  );

endmodule

// ==== design/vlsu_vrf_seq.sv ====
// Register file sequencer of the vector load/store unit
// Drains load words into registers in order, reads store words into the buffer
`timescale 1ns/1ps
`include "vlsu_defs.svh"

module vlsu_vrf_seq (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  vlsu_op_pkg::vlsu_job_t job_i,
  input  logic                   start_i,
  input  logic                   active_i,
  input  logic                   full_i,
  input  logic                   head_valid_i,
  input  vlsu_bus_pkg::word_t    head_data_i,
  output logic                   pop_o,
  output logic                   append_o,
  output vlsu_bus_pkg::word_t    append_data_o,
  output vlsu_bus_pkg::vrf_wr_t  vrf_wr_o,
  output logic                   vrf_we_o,
  input  logic                   vrf_wvalid_i,
  output vlsu_bus_pkg::vrf_addr_t vrf_raddr_o,
  output logic                   vrf_re_o,
  input  vlsu_bus_pkg::word_t    vrf_rdata_i,
  input  logic                   vrf_rvalid_i,
  output logic                   busy_o
);

  vlsu_op_pkg::vl_t        done_q;
  vlsu_op_pkg::vl_t        remaining;
  vlsu_op_pkg::vl_t        step;
  vlsu_bus_pkg::vrf_addr_t vreg_addr;
  logic                    is_load;
  logic                    pending;
  logic                    beat;

  assign is_load   = job_i.op == vlsu_op_pkg::OP_LOAD;
  assign remaining = job_i.nbytes - done_q;
  assign step      = (remaining < vlsu_op_pkg::vl_t'(4)) ? remaining : vlsu_op_pkg::vl_t'(4);
  assign pending   = active_i & ~start_i & (remaining != '0);
  assign busy_o    = active_i & (remaining != '0);

  // vd * 8 + word index, long vectors spill into the next registers
  assign vreg_addr = {job_i.vd, {`VLSU_VREG_WORDS_LOG{1'b0}}}
                   + vlsu_bus_pkg::vrf_addr_t'(done_q >> 2);

  ////////////////////////////////////////
  // Load drain and store fetch
  ////////////////////////////////////////

  assign vrf_we_o      = pending & is_load & head_valid_i;
  assign vrf_wr_o.addr = vreg_addr;
  assign vrf_wr_o.data = head_data_i;
  assign vrf_wr_o.be   = vlsu_bus_pkg::low_strb(remaining);
  assign pop_o         = vrf_we_o & vrf_wvalid_i;

  // Stop reading while the buffer has no room
  assign vrf_re_o      = pending & ~is_load & ~full_i;
  assign vrf_raddr_o   = vreg_addr;
  assign append_o      = vrf_re_o & vrf_rvalid_i;
  assign append_data_o = vrf_rdata_i;

  assign beat = pop_o | append_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      done_q <= '0;
    end else if (beat) begin
      done_q <= done_q + step;
    end
  end

endmodule

// ==== design/vlsu_mem_seq.sv ====
// Memory sequencer of the vector load/store unit
// Walks the job one word per beat and issues tagged loads or strobed stores
`timescale 1ns/1ps

module vlsu_mem_seq (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  vlsu_op_pkg::vlsu_job_t job_i,
  input  logic                   start_i,
  input  logic                   active_i,
  input  logic                   full_i,
  output logic                   alloc_o,
  input  vlsu_bus_pkg::tag_t     alloc_tag_i,
  input  logic                   head_valid_i,
  input  vlsu_bus_pkg::word_t    head_data_i,
  output logic                   pop_o,
  output vlsu_bus_pkg::mem_req_t mem_req_o,
  output logic                   mem_valid_o,
  input  logic                   mem_ready_i,
  output logic                   busy_o
);

  vlsu_op_pkg::vl_t done_q;
  vlsu_op_pkg::vl_t remaining;
  vlsu_op_pkg::vl_t step;
  logic             is_load;
  logic             last;
  logic             pending;
  logic             xfer;

  assign is_load   = job_i.op == vlsu_op_pkg::OP_LOAD;
  assign remaining = job_i.nbytes - done_q;
  assign last      = remaining <= vlsu_op_pkg::vl_t'(4);
  assign step      = last ? remaining : vlsu_op_pkg::vl_t'(4);
  // Counter is only fresh after the start cycle
  assign pending   = active_i & ~start_i & (remaining != '0);

  // Loads need a free tag, stores need the head word
  assign mem_valid_o = pending & (is_load ? ~full_i : head_valid_i);
  assign xfer        = mem_valid_o & mem_ready_i;
  assign alloc_o     = xfer & is_load;
  assign pop_o       = xfer & ~is_load;
  assign busy_o      = active_i & (remaining != '0);

  ////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////

  always_comb begin
    // Write pointer moves with store appends, so stores carry tag 0
    mem_req_o.tag   = is_load ? alloc_tag_i : '0;
    mem_req_o.addr  = job_i.base + vlsu_op_pkg::addr_t'(done_q);
    mem_req_o.we    = ~is_load;
    mem_req_o.strb  = vlsu_bus_pkg::low_strb(remaining);
    mem_req_o.wdata = is_load ? '0 : head_data_i;
    mem_req_o.last  = last;
  end

  // Byte counter, beat n sits at base + 4n
  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      done_q <= '0;
    end else if (xfer) begin
      done_q <= done_q + step;
    end
  end

endmodule

// ==== design/vlsu_reorder_buffer.sv ====
// Reorder buffer of the vector load/store unit
// Hands out tags, takes fills in any order and drains them in tag order
`timescale 1ns/1ps
`include "vlsu_defs.svh"

module vlsu_reorder_buffer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                start_i,
  input  logic                alloc_i,
  output vlsu_bus_pkg::tag_t  alloc_tag_o,
  input  logic                fill_i,
  input  vlsu_bus_pkg::tag_t  fill_tag_i,
  input  vlsu_bus_pkg::word_t fill_data_i,
  input  logic                append_i,
  input  vlsu_bus_pkg::word_t append_data_i,
  output logic                head_valid_o,
  output vlsu_bus_pkg::word_t head_data_o,
  input  logic                pop_i,
  output logic                full_o
);

  vlsu_bus_pkg::tag_t                   wptr_q;
  vlsu_bus_pkg::tag_t                   rptr_q;
  logic [$clog2(`VLSU_ROB_DEPTH+1)-1:0] used_q;
  logic [`VLSU_ROB_DEPTH-1:0]           valid_q;
  vlsu_bus_pkg::word_t                  data_q [`VLSU_ROB_DEPTH];
  logic                                 push;

  // A load tag or a store word both take the next entry
  assign push = alloc_i | append_i;

  assign alloc_tag_o  = wptr_q;
  assign head_valid_o = valid_q[rptr_q];
  assign head_data_o  = data_q[rptr_q];
  assign full_o       = used_q == `VLSU_ROB_DEPTH;

  ////////////////////////////////////////
  // Pointers and entry state
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      used_q  <= '0;
      valid_q <= '0;
    end else begin
      // Pointers wrap with the 3-bit tag
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !pop_i) begin
        used_q <= used_q + 1'b1;
      end else if (pop_i && !push) begin
        used_q <= used_q - 1'b1;
      end
      // Popped entry is never the one being filled
      if (pop_i) begin
        valid_q[rptr_q] <= 1'b0;
      end
      if (fill_i) begin
        valid_q[fill_tag_i] <= 1'b1;
      end
      if (append_i) begin
        valid_q[wptr_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      data_q[fill_tag_i] <= fill_data_i;
    end
    if (append_i) begin
      data_q[wptr_q] <= append_data_i;
    end
  end

endmodule

// ==== design/vlsu_req_ctrl.sv ====
// Request control of the vector load/store unit
// Accepts one request, turns vl into a byte count and waits for both sequencers
`timescale 1ns/1ps

module vlsu_req_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  vlsu_op_pkg::vlsu_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   mem_busy_i,
  input  logic                   vrf_busy_i,
  output vlsu_op_pkg::vlsu_job_t job_o,
  output logic                   start_o,
  output logic                   active_o
);

  typedef enum logic [1:0] {
    IDLE,
    START,
    RUN
  } state_e;

  state_e                 state_q, state_d;
  vlsu_op_pkg::vlsu_job_t job_q;
  vlsu_op_pkg::vl_t       nbytes;
  logic                   accept;
  logic                   new_job;

  assign accept  = req_valid_i & req_ready_o;
  // Zero length requests never leave IDLE
  assign new_job = accept & (nbytes != '0);

  // Bytes = vl << vsew
  always_comb begin
    case (req_i.vsew)
      vlsu_op_pkg::EW_8:  nbytes = req_i.vl;
      vlsu_op_pkg::EW_16: nbytes = req_i.vl << 1;
      vlsu_op_pkg::EW_32: nbytes = req_i.vl << 2;
      default:            nbytes = '0;
    endcase
  end

  ////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (new_job) begin
          state_d = START;
        end
      end
      START: state_d = RUN;
      RUN: begin
        if (!mem_busy_i && !vrf_busy_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_job) begin
      job_q.op     <= req_i.op;
      job_q.vd     <= req_i.vd;
      job_q.base   <= req_i.rs1;
      job_q.nbytes <= nbytes;
    end
  end

  assign job_o       = job_q;
  assign start_o     = state_q == START;
  assign active_o    = state_q != IDLE;
  assign req_ready_o = ~active_o;

endmodule

// ==== design/vlsu_bus_pkg.sv ====
// Bus records of the vector load/store unit
// Memory requests and results, register file writes and strobe helper
`include "vlsu_defs.svh"

package vlsu_bus_pkg;

  typedef logic [`VLSU_WORD_W-1:0]            word_t;
  typedef logic [`VLSU_WORD_W/8-1:0]          strb_t;
  typedef logic [$clog2(`VLSU_ROB_DEPTH)-1:0] tag_t;
  typedef logic [`VLSU_VRF_ADDR_W-1:0]        vrf_addr_t;

  typedef struct packed {
    tag_t               tag;
    vlsu_op_pkg::addr_t addr;
    logic               we;
    strb_t              strb;
    word_t              wdata;
    logic               last;
  } mem_req_t;

  // Load data coming back, possibly out of order
  typedef struct packed {
    tag_t  tag;
    word_t rdata;
  } mem_result_t;

  typedef struct packed {
    vrf_addr_t addr;
    word_t     data;
    strb_t     be;
  } vrf_wr_t;

  // Byte enables for the low min(4, remaining) bytes of a word
  function automatic strb_t low_strb(vlsu_op_pkg::vl_t remaining);
    strb_t strb;
    for (int k = 0; k < $bits(strb_t); k++) begin
      strb[k] = remaining > vlsu_op_pkg::vl_t'(k);
    end
    return strb;
  endfunction

endpackage

// ==== design/vlsu_op_pkg.sv ====
// Request side types of the vector load/store unit
// Operations, element widths, incoming requests and decoded jobs
`include "vlsu_defs.svh"

package vlsu_op_pkg;

  typedef logic [`VLSU_ADDR_W-1:0] addr_t;
  typedef logic [`VLSU_VL_W-1:0]   vl_t;
  typedef logic [4:0]              vreg_idx_t;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } vlsu_op_e;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef struct packed {
    vlsu_op_e  op;
    vreg_idx_t vd;
    addr_t     rs1;
    vl_t       vl;
    vsew_e     vsew;
  } vlsu_req_t;

  // Accepted request with vl already turned into bytes
  typedef struct packed {
    vlsu_op_e  op;
    vreg_idx_t vd;
    addr_t     base;
    vl_t       nbytes;
  } vlsu_job_t;

endpackage

// ==== design/vlsu_defs.svh ====
// Vector load/store unit constants
// Bus widths, reorder buffer depth and vector register size
`ifndef VLSU_DEFS_SVH
`define VLSU_DEFS_SVH

// Memory address width
`define VLSU_ADDR_W 32

// Data word width, one word per beat
`define VLSU_WORD_W 32

// Vector length and byte count width
`define VLSU_VL_W 9

// Outstanding tags in the reorder buffer
`define VLSU_ROB_DEPTH 8

// Log2 of the words held by one vector register
`define VLSU_VREG_WORDS_LOG 3

// Register file word address width
`define VLSU_VRF_ADDR_W 8

`endif
